// ==== Makefile ====
# Verilator flow for the min/max slice

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TB_TOP    := tb_minmax_slice
RTL_TOP   := minmax_slice
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+hw
+incdir+testbench
hw/fpslice_pkg.sv
hw/slice_ctrl.sv
hw/operand_unpack.sv
hw/minmax_lane.sv
hw/result_pack.sv
hw/minmax_slice.sv
testbench/tb_minmax_slice.sv

// ==== hw/fpslice_consts.svh ====
// Global constants of the min/max slice
// Include wherever a width, lane count or canonical NaN is needed

`ifndef FPSLICE_CONSTS_SVH
`define FPSLICE_CONSTS_SVH

// Slice geometry
`define SLICE_WIDTH 32          // Operand and result word
`define NUM_LANES 2             // FP16 vector lanes
`define LANE_PIPE_REGS 2        // Register stages per lane
`define TAG_WIDTH 4             // User tag carried with each request

// Canonical quiet NaNs
`define FP16_QNAN 16'h7e00
`define FP32_QNAN 32'h7fc0_0000

`endif

// ==== hw/fpslice_pkg.sv ====
// Types shared by the min/max slice, its lanes and the testbench
// Modules take these by a wildcard import in their header

`include "fpslice_consts.svh"

package fpslice_pkg;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic {
    MIN = 1'b0,
    MAX = 1'b1
  } minmax_op_e;

  typedef struct packed {
    logic       sign;
    logic [4:0] exponent;
    logic [9:0] mantissa;
  } fp16_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  // One slice word, read as a scalar FP32 or as two FP16 halves
  typedef union packed {
    fp32_t                          fp32;
    fp16_t [`NUM_LANES-1:0]         fp16;
  } fp_word_u;

  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Sideband info that rides through the lane pipeline
  typedef struct packed {
    fp_fmt_e                fmt;
    logic                   vectorial;
    logic [`TAG_WIDTH-1:0]  tag;
  } lane_aux_t;

  typedef struct packed {
    fp_word_u               a;
    fp_word_u               b;
    minmax_op_e             op;
    fp_fmt_e                fmt;
    logic                   vectorial;
    logic [`TAG_WIDTH-1:0]  tag;
  } slice_req_t;

  typedef struct packed {
    fp_word_u   a;    // FP16 operands sit in the low half
    fp_word_u   b;
    minmax_op_e op;
    fp_fmt_e    fmt;  // Format this lane computes in
    lane_aux_t  aux;
  } lane_req_t;

  typedef struct packed {
    fp_word_u  result;
    status_t   status;
    lane_aux_t aux;
  } lane_res_t;

  typedef struct packed {
    fp_word_u               result;
    status_t                status;
    logic [`TAG_WIDTH-1:0]  tag;
  } slice_res_t;

endpackage

// ==== hw/minmax_lane.sv ====
// One lane of IEEE 754-2008 minNum/maxNum in FP32 or FP16
// The result is followed by an elastic pipeline of LANE_PIPE_REGS stages

`timescale 1ns/100ps
`include "fpslice_consts.svh"

module minmax_lane
  import fpslice_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      flush_i,
  input  lane_req_t req_i,
  input  logic      in_valid_i,
  input  logic      out_ready_i,
  output logic      in_ready_o,
  output lane_res_t res_o,
  output logic      out_valid_o,
  output logic      busy_o
);

  localparam int unsigned NumRegs = `LANE_PIPE_REGS;

  logic        sign_a, sign_b;
  logic [30:0] mag_a, mag_b;  // Exponent and mantissa, FP16 zero extended
  logic        nan_a, nan_b;
  logic        snan_a, snan_b;
  logic        a_lt_b, take_a;
  fp_word_u    qnan;
  lane_res_t   op_res;

  // Index i holds the item after i register stages
  lane_res_t pipe_data  [0:NumRegs];
  logic      pipe_valid [0:NumRegs];
  logic      pipe_ready [0:NumRegs];

  function automatic void classify(input fp_word_u w, input fp_fmt_e fmt,
                                   output logic sign, output logic [30:0] mag,
                                   output logic is_nan, output logic is_snan);
    if (fmt == FP32) begin
      sign    = w.fp32.sign;
      mag     = {w.fp32.exponent, w.fp32.mantissa};
      is_nan  = (&w.fp32.exponent) & (|w.fp32.mantissa);
      is_snan = is_nan & ~w.fp32.mantissa[22];  // Quiet bit clear
    end else begin
      sign    = w.fp16[0].sign;
      mag     = {16'b0, w.fp16[0].exponent, w.fp16[0].mantissa};
      is_nan  = (&w.fp16[0].exponent) & (|w.fp16[0].mantissa);
      is_snan = is_nan & ~w.fp16[0].mantissa[9];
    end
  endfunction

  // ----------------------------------------------------------
  // Min/max datapath
  // ----------------------------------------------------------
  always_comb begin
    classify(req_i.a, req_i.fmt, sign_a, mag_a, nan_a, snan_a);
    classify(req_i.b, req_i.fmt, sign_b, mag_b, nan_b, snan_b);

    // Sign decides first, so -0 orders below +0
    if (sign_a != sign_b) a_lt_b = sign_a;
    else if (sign_a)      a_lt_b = mag_a > mag_b;
    else                  a_lt_b = mag_a < mag_b;
    take_a = (req_i.op == MIN) ? a_lt_b : ~a_lt_b;

    qnan = (req_i.fmt == FP32) ? `FP32_QNAN : {16'hffff, `FP16_QNAN};

    op_res = '0;
    if (nan_a && nan_b)  op_res.result = qnan;
    else if (nan_a)      op_res.result = req_i.b;  // A single NaN loses
    else if (nan_b)      op_res.result = req_i.a;
    else                 op_res.result = take_a ? req_i.a : req_i.b;
    if (req_i.fmt == FP16) op_res.result.fp16[1] = '1;
    op_res.status.nv = snan_a | snan_b;
    op_res.aux       = req_i.aux;
  end

  // ----------------------------------------------------------
  // Elastic pipeline
  // ----------------------------------------------------------
  assign pipe_data[0]  = op_res;
  assign pipe_valid[0] = in_valid_i;

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic reg_ena;

    // Advance when the next stage moves on or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];
    assign reg_ena       = pipe_ready[i] & pipe_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid[i+1] <= pipe_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) pipe_data[i+1] <= pipe_data[i];
    end
  end

  assign pipe_ready[NumRegs] = out_ready_i;  // Driven from downstream
  assign in_ready_o          = pipe_ready[0];
  assign out_valid_o         = pipe_valid[NumRegs];
  assign res_o               = pipe_data[NumRegs];

  always_comb begin : busy
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumRegs); i++) busy_o |= pipe_valid[i];
  end

endmodule

// ==== hw/minmax_slice.sv ====
// Top of the min/max slice: FP32 scalar or FP16 scalar/two-lane vector
// Valid/ready on both sides, results leave in request order

`timescale 1ns/100ps
`include "fpslice_consts.svh"

module minmax_slice
  import fpslice_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  slice_req_t req_i,
  input  logic       in_valid_i,
  input  logic       flush_i,
  input  logic       out_ready_i,
  output logic       in_ready_o,
  output slice_res_t res_o,
  output logic       out_valid_o,
  output logic       busy_o
);

  lane_req_t [`NUM_LANES-1:0] lane_req;
  lane_res_t [`NUM_LANES-1:0] lane_res;
  logic      [`NUM_LANES-1:0] lane_in_valid, lane_in_ready;
  logic      [`NUM_LANES-1:0] lane_out_valid, lane_out_ready;
  logic      [`NUM_LANES-1:0] lane_busy;

  slice_ctrl i_ctrl (
    .clk_i            ( clk_i                      ),
    .arst_n_i         ( arst_n_i                   ),
    .in_valid_i       ( in_valid_i                 ),
    .vectorial_i      ( lane_req[0].aux.vectorial  ),
    .flush_i          ( flush_i                    ),
    .out_ready_i      ( out_ready_i                ),
    .lane_in_ready_i  ( lane_in_ready              ),
    .lane_out_valid_i ( lane_out_valid             ),
    .lane_busy_i      ( lane_busy                  ),
    .res_vectorial_i  ( lane_res[0].aux.vectorial  ),
    .in_ready_o       ( in_ready_o                 ),
    .lane_in_valid_o  ( lane_in_valid              ),
    .lane_out_ready_o ( lane_out_ready             ),
    .out_valid_o      ( out_valid_o                ),
    .busy_o           ( busy_o                     )
  );

  operand_unpack i_unpack (
    .req_i      ( req_i    ),
    .lane_req_o ( lane_req )
  );

  // ----------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------
  for (genvar l = 0; l < `NUM_LANES; l++) begin : gen_lanes
    minmax_lane i_lane (
      .clk_i       ( clk_i              ),
      .arst_n_i    ( arst_n_i           ),
      .flush_i     ( flush_i            ),
      .req_i       ( lane_req[l]        ),
      .in_valid_i  ( lane_in_valid[l]   ),
      .out_ready_i ( lane_out_ready[l]  ),
      .in_ready_o  ( lane_in_ready[l]   ),
      .res_o       ( lane_res[l]        ),
      .out_valid_o ( lane_out_valid[l]  ),
      .busy_o      ( lane_busy[l]       )
    );
  end

  result_pack i_pack (
    .lane_res_i       ( lane_res       ),
    .lane_out_valid_i ( lane_out_valid ),
    .res_o            ( res_o          )
  );

endmodule

// ==== hw/operand_unpack.sv ====
// Splits a slice request into one lane request per lane
// Scalar FP16 operands must be NaN-boxed, otherwise they become the canonical NaN

`timescale 1ns/100ps
`include "fpslice_consts.svh"

module operand_unpack
  import fpslice_pkg::*;
(
  input  slice_req_t                   req_i,
  output lane_req_t [`NUM_LANES-1:0]   lane_req_o
);

  logic is_vec;

  // Vector only makes sense for FP16
  assign is_vec = req_i.vectorial & (req_i.fmt == FP16);

  // Low half of a scalar FP16 operand, checked for proper boxing
  function automatic fp16_t unbox_fp16(input fp_word_u w);
    fp16_t val;
    val = w.fp16[0];
    if (w.fp16[1] != 16'hffff) val = `FP16_QNAN;
    return val;
  endfunction

  for (genvar l = 0; l < `NUM_LANES; l++) begin : gen_lane
    always_comb begin : unpack
      lane_req_o[l].a = '1;  // Unused upper bits stay boxed
      lane_req_o[l].b = '1;
      if (req_i.fmt == FP32 && l == 0) begin
        lane_req_o[l].a = req_i.a;
        lane_req_o[l].b = req_i.b;
      end else if (l == 0 && !is_vec) begin
        lane_req_o[l].a.fp16[0] = unbox_fp16(req_i.a);
        lane_req_o[l].b.fp16[0] = unbox_fp16(req_i.b);
      end else begin
        lane_req_o[l].a.fp16[0] = req_i.a.fp16[l];  // Lane n takes half n
        lane_req_o[l].b.fp16[0] = req_i.b.fp16[l];
      end
      lane_req_o[l].op            = req_i.op;
      lane_req_o[l].fmt           = (l == 0) ? req_i.fmt : FP16;
      lane_req_o[l].aux.fmt       = req_i.fmt;
      lane_req_o[l].aux.vectorial = is_vec;
      lane_req_o[l].aux.tag       = req_i.tag;
    end
  end

endmodule

// ==== hw/result_pack.sv ====
// Packs the lane results into one slice word by format
// Unused upper bits are NaN-boxed and lane status flags are ORed

`timescale 1ns/100ps
`include "fpslice_consts.svh"

module result_pack
  import fpslice_pkg::*;
(
  input  lane_res_t [`NUM_LANES-1:0] lane_res_i,
  input  logic      [`NUM_LANES-1:0] lane_out_valid_i,
  output slice_res_t                 res_o
);

  lane_aux_t            aux;   // Lane 0 speaks for the whole result
  logic [`NUM_LANES-1:0] used;

  assign aux = lane_res_i[0].aux;

  // Upper lanes only count for vector results
  for (genvar l = 0; l < `NUM_LANES; l++) begin : gen_used
    assign used[l] = lane_out_valid_i[l] & ((l == 0) | aux.vectorial);
  end

  // ----------------------------------------------------------
  // Result word
  // ----------------------------------------------------------
  always_comb begin : pack
    res_o.result = '1;  // NaN-box by default
    if (aux.fmt == FP32) begin
      res_o.result = lane_res_i[0].result;
    end else begin
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (used[l]) res_o.result.fp16[l] = lane_res_i[l].result.fp16[0];
      end
    end
  end

  // ----------------------------------------------------------
  // Status and tag
  // ----------------------------------------------------------
  always_comb begin : collapse
    res_o.status = '0;
    for (int l = 0; l < `NUM_LANES; l++) begin
      if (used[l]) res_o.status |= lane_res_i[l].status;
    end
  end

  assign res_o.tag = aux.tag;

endmodule

// ==== hw/slice_ctrl.sv ====
// Handshake control for the slice
// Gates lane valids for vector requests and keeps the lanes in lockstep

`timescale 1ns/100ps
`include "fpslice_consts.svh"

module slice_ctrl (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  input  logic                  vectorial_i,
  input  logic                  flush_i,
  input  logic                  out_ready_i,
  input  logic [`NUM_LANES-1:0] lane_in_ready_i,
  input  logic [`NUM_LANES-1:0] lane_out_valid_i,
  input  logic [`NUM_LANES-1:0] lane_busy_i,
  input  logic                  res_vectorial_i,  // Vector flag of the result at lane 0 output
  output logic                  in_ready_o,
  output logic [`NUM_LANES-1:0] lane_in_valid_o,
  output logic [`NUM_LANES-1:0] lane_out_ready_o,
  output logic                  out_valid_o,
  output logic                  busy_o
);

  logic lanes_ready;
  logic flush_pend_q;

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  // Lanes run in lockstep, so this equals the lane 0 ready
  assign lanes_ready = lane_in_ready_i[0] & (~vectorial_i | (&lane_in_ready_i));
  assign in_ready_o  = lanes_ready;

  for (genvar l = 0; l < `NUM_LANES; l++) begin : gen_lane_hs
    // Upper lanes only see vector requests
    assign lane_in_valid_o[l] = in_valid_i & lanes_ready & ((l == 0) | vectorial_i);
    // Upper lanes pop only together with a vector result on lane 0
    assign lane_out_ready_o[l] = out_ready_i & ((l == 0) | res_vectorial_i);
  end

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------
  assign out_valid_o = lane_out_valid_i[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flush_pend_q <= 1'b0;
    end else begin
      flush_pend_q <= flush_i;
    end
  end

  // Stages are being emptied right after a flush
  assign busy_o = (|lane_busy_i) & ~flush_pend_q;

endmodule

// ==== testbench/minmax_model.svh ====
// Reference model of the min/max slice, included inside the testbench module
// Expects fpslice_pkg to be imported and the constants header to be included first

`ifndef MINMAX_MODEL_SVH
`define MINMAX_MODEL_SVH

// NaN tests on the low half (FP16) or the whole word (FP32)
function automatic logic nan_of(input logic [31:0] v, input bit half);
  if (half) return (&v[14:10]) & (|v[9:0]);
  return (&v[30:23]) & (|v[22:0]);
endfunction

function automatic logic snan_of(input logic [31:0] v, input bit half);
  return nan_of(v, half) & ~(half ? v[9] : v[22]);  // Quiet bit clear
endfunction

// Signed scale where -0 sits one step below +0
function automatic longint order_key(input logic [31:0] v, input bit half);
  longint mag;
  mag = half ? longint'(v[14:0]) : longint'(v[30:0]);
  if (half ? v[15] : v[31]) return -mag - 1;
  return mag;
endfunction

// minNum/maxNum of IEEE 754-2008
function automatic logic [31:0] pick(input logic [31:0] a, input logic [31:0] b,
                                     input bit half, input minmax_op_e op);
  longint ka;
  longint kb;
  ka = order_key(a, half);
  kb = order_key(b, half);
  if (nan_of(a, half) && nan_of(b, half)) return half ? {16'h0, `FP16_QNAN} : `FP32_QNAN;
  if (nan_of(a, half)) return b;
  if (nan_of(b, half)) return a;
  if (op == MIN) return (ka <= kb) ? a : b;
  return (ka >= kb) ? a : b;
endfunction

// Badly boxed scalar FP16 reads as the canonical NaN
function automatic logic [15:0] unboxed(input logic [31:0] w);
  if (w[31:16] != 16'hffff) return `FP16_QNAN;
  return w[15:0];
endfunction

function automatic slice_res_t expected_result(input slice_req_t r);
  slice_res_t  e;
  logic [31:0] aw, bw, word, t;
  logic [15:0] a16, b16;
  e    = '0;
  aw   = r.a;
  bw   = r.b;
  word = '1;
  if (r.fmt == FP32) begin
    word        = pick(aw, bw, 1'b0, r.op);
    e.status.nv = snan_of(aw, 1'b0) | snan_of(bw, 1'b0);
  end else begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      a16 = r.vectorial ? aw[16*l +: 16] : unboxed(aw);
      b16 = r.vectorial ? bw[16*l +: 16] : unboxed(bw);
      if (r.vectorial || l == 0) begin
        t                = pick({16'h0, a16}, {16'h0, b16}, 1'b1, r.op);
        word[16*l +: 16] = t[15:0];
        e.status.nv      = e.status.nv | snan_of({16'h0, a16}, 1'b1) |
                           snan_of({16'h0, b16}, 1'b1);
      end
    end
  end
  e.result = word;
  e.tag    = r.tag;
  return e;
endfunction

`endif

// ==== testbench/tb_minmax_slice.sv ====
// Testbench for the min/max slice
// Directed corner cases, then random requests under back-pressure, checked in order

`timescale 1ns/100ps
`include "fpslice_consts.svh"

module tb_minmax_slice
  import fpslice_pkg::*;
();

  localparam int WaitLimit = 200;  // Cycles before a wait gives up
  localparam int NumRandom = 400;

  logic       clk_i, arst_n_i, in_valid_i, flush_i, out_ready_i;
  logic       in_ready_o, out_valid_o, busy_o;
  slice_req_t req_i;
  slice_res_t res_o;

  logic [31:0]           rng_state = 32'h2b2d_a1be;
  logic [`TAG_WIDTH-1:0] tag_cnt   = '0;
  int         n_value_err = 0;
  int         n_proto_err = 0;
  int         cyc         = 0;
  bit         bp_mode     = 0;   // Random out_ready_i
  bit         strict_lat  = 0;   // Latency must be exact
  slice_res_t exp_q[$];
  int         acc_q[$];          // Accept cycle of each pending request

  `include "minmax_model.svh"

  minmax_slice dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // ----------------------------------------------------------
  // Compare tasks and run control
  // ----------------------------------------------------------
  task automatic check_word(input fp_word_u got, input fp_word_u exp);
    if (got !== exp) begin
      $display("error @ %0t: result %08h, expected %08h", $time, got, exp);
      n_value_err++;
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("error @ %0t: status %05b, expected %05b", $time, got, exp);
      n_value_err++;
    end
  endtask

  task automatic check_tag(input logic [`TAG_WIDTH-1:0] got,
                           input logic [`TAG_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("error @ %0t: tag %0h, expected %0h", $time, got, exp);
      n_value_err++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("error @ %0t: %s is %0b, expected %0b", $time, name, got, exp);
      n_proto_err++;
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d value, %0d protocol", n_value_err, n_proto_err);
    if (n_value_err == 0 && n_proto_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", WaitLimit, what);
    n_proto_err++;
    finish_run();
  endtask

  // ----------------------------------------------------------
  // Scoreboard, sampled mid-cycle where all signals are stable
  // ----------------------------------------------------------
  always @(negedge clk_i) begin
    if (arst_n_i && !flush_i) begin
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("A result with tag %0h came out with no request pending", res_o.tag);
          n_proto_err++;
        end else begin
          check_word(res_o.result, exp_q[0].result);
          check_status(res_o.status, exp_q[0].status);
          check_tag(res_o.tag, exp_q[0].tag);
          if (strict_lat && (cyc - acc_q[0]) != `LANE_PIPE_REGS) begin
            $display("error @ %0t: latency %0d cycles, expected %0d", $time,
                     cyc - acc_q[0], `LANE_PIPE_REGS);
            n_proto_err++;
          end
          void'(exp_q.pop_front());
          void'(acc_q.pop_front());
        end
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(expected_result(req_i));
        acc_q.push_back(cyc);
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Half of the draws land on NaNs, zeros or infinities
  function automatic logic [15:0] rand16();
    logic [31:0] sel, v;
    sel = next_rand();
    v   = next_rand();
    case (sel[2:0])
      3'd0:    return {v[15], 5'h1f, 1'b1, v[8:0]};
      3'd1:    return {v[15], 5'h1f, 1'b0, v[8:1], 1'b1};
      3'd2:    return {v[15], 15'h0};
      3'd3:    return {v[15], 5'h1f, 10'h0};
      default: return v[15:0];
    endcase
  endfunction

  function automatic logic [31:0] rand32();
    logic [31:0] sel, v;
    sel = next_rand();
    v   = next_rand();
    case (sel[2:0])
      3'd0:    return {v[31], 8'hff, 1'b1, v[21:0]};
      3'd1:    return {v[31], 8'hff, 1'b0, v[21:1], 1'b1};
      3'd2:    return {v[31], 31'h0};
      3'd3:    return {v[31], 8'hff, 23'h0};
      default: return v;
    endcase
  endfunction

  function automatic slice_req_t rand_req();
    slice_req_t  r;
    logic [31:0] sel, a, b;
    sel         = next_rand();
    r.fmt       = sel[0] ? FP16 : FP32;
    r.vectorial = sel[1];
    r.op        = minmax_op_e'(sel[2]);
    a = (r.fmt == FP32) ? rand32() : {rand16(), rand16()};
    b = (r.fmt == FP32) ? rand32() : {rand16(), rand16()};
    if (r.fmt == FP16 && !r.vectorial && |sel[5:3]) begin
      a[31:16] = '1;  // Mostly well boxed
      b[31:16] = '1;
    end
    if (~|sel[8:6]) b = a;
    r.a   = a;
    r.b   = b;
    r.tag = '0;
    return r;
  endfunction

  task automatic next_cycle();
    logic [31:0] v;
    @(posedge clk_i);
    #2;
    v = next_rand();
    if (bp_mode) out_ready_i = (v & 32'h3) != 32'h0;
  endtask

  // Holds the request until it is taken
  task automatic send(input slice_req_t r);
    int waited;
    bit taken;
    waited     = 0;
    taken      = 0;
    req_i      = r;
    req_i.tag  = tag_cnt;
    tag_cnt    = tag_cnt + 1'b1;
    in_valid_i = 1'b1;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      next_cycle();
      waited++;
      if (!taken && waited > WaitLimit) report_timeout("in_ready_o");
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send_both(input logic [31:0] a, input logic [31:0] b,
                           input fp_fmt_e fmt, input logic vec);
    slice_req_t r;
    r.a         = a;
    r.b         = b;
    r.fmt       = fmt;
    r.vectorial = vec;
    r.tag       = '0;
    for (int o = 0; o < 2; o++) begin
      r.op = minmax_op_e'(o);
      send(r);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > WaitLimit) report_timeout("pending results");
    end
  endtask

  task automatic flush_pipe();
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    flush_i     = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    exp_q.delete();  // Whatever was in flight is gone
    acc_q.delete();
    @(negedge clk_i);
    check_flag(out_valid_o, 1'b0, "out_valid_o after flush");
    check_flag(busy_o, 1'b0, "busy_o after flush");
    next_cycle();
  endtask

  initial begin
    slice_req_t r;
    req_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    arst_n_i    = 1'b0;
    repeat (8) @(posedge clk_i);
    #2 arst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
    check_flag(busy_o, 1'b0, "busy_o after reset");
    check_flag(in_ready_o, 1'b1, "in_ready_o after reset");
    next_cycle();

    // Directed corner cases, back to back
    strict_lat = 1;
    send_both(32'h0000_0000, 32'h8000_0000, FP32, 1'b0);  // +0 against -0
    send_both(32'h3f80_0000, 32'h7fc0_1234, FP32, 1'b0);  // One quiet NaN
    send_both(32'h7fa0_0000, 32'h7fc0_0000, FP32, 1'b0);  // Two NaNs, one signalling
    send_both(32'hbfc0_0000, 32'h4020_0000, FP32, 1'b0);
    send_both(32'h8000_3c00, 32'h0000_7d00, FP16, 1'b1);  // sNaN in the low lane only
    send_both(32'h7e00_c000, 32'hfc00_4200, FP16, 1'b1);
    send_both(32'h1234_3c00, 32'hffff_4000, FP16, 1'b0);  // a is badly boxed
    send_both(32'hffff_8000, 32'hfffe_0000, FP16, 1'b0);
    drain();
    strict_lat = 0;

    // Fill both stages, then flush them
    out_ready_i = 1'b0;
    send_both(32'h4000_0000, 32'h3f80_0000, FP32, 1'b0);
    @(negedge clk_i);
    check_flag(in_ready_o, 1'b0, "in_ready_o with both stages full");
    check_flag(busy_o, 1'b1, "busy_o with both stages full");
    next_cycle();
    flush_pipe();
    out_ready_i = 1'b1;

    // Random traffic under back-pressure
    bp_mode = 1;
    for (int n = 0; n < NumRandom; n++) begin
      r = rand_req();
      send(r);
      if ((next_rand() & 32'h3) == 32'h0) next_cycle();
      if (n == NumRandom / 2) flush_pipe();
    end
    bp_mode     = 0;
    out_ready_i = 1'b1;
    drain();
    finish_run();
  end

endmodule
